//--- common/fft_pkg.sv
/*
 * FFT shared definitions
 * Complex sample and twiddle types, per-stage control word and the
 * constants of the 16-point R2SDF pipeline
 */
`default_nettype none

package fft_pkg;

    // ******************************************************************
    // Sizes
    // ******************************************************************
    localparam int DATA_W   = 16;           // Real and imaginary width
    localparam int TW_W     = 8;            // Twiddle width
    localparam int TW_FRAC  = 6;            // Q1.6 twiddles
    localparam int FFT_N    = 16;
    localparam int N_STAGES = 4;
    localparam int PIPE_LAT = 19;           // Steps until the first bin

    // Step count at which each stage sees element 0 of a frame
    localparam logic [N_STAGES-1:0][4:0] STAGE_OFS = {5'd17, 5'd14, 5'd9, 5'd0};

    // ******************************************************************
    // Types
    // ******************************************************************
    typedef struct packed {
        logic signed [DATA_W-1:0] re;
        logic signed [DATA_W-1:0] im;
    } cplx_t;

    typedef struct packed {
        logic signed [TW_W-1:0] re;
        logic signed [TW_W-1:0] im;
    } tw_t;

    typedef struct packed {
        logic       compute;                // Second half of the window
        logic [2:0] tw_idx;                 // Index into W16 table
    } stage_ctrl_t;

endpackage

`default_nettype wire

//--- hw/butterfly/r2_butterfly.sv
/*
 * Radix-2 SDF butterfly
 * Fill phase stores the new sample and emits the rotated difference,
 * compute phase emits the halved sum and feeds back the halved difference
 */
`default_nettype none

module r2_butterfly (
    input  logic           compute_i,
    input  fft_pkg::cplx_t a_i,             // New sample
    input  fft_pkg::cplx_t b_i,             // From the delay line
    input  fft_pkg::tw_t   tw_i,
    output fft_pkg::cplx_t out_o,
    output fft_pkg::cplx_t fb_o
);
    import fft_pkg::*;

    logic signed [DATA_W:0]      sum_re;
    logic signed [DATA_W:0]      sum_im;
    logic signed [DATA_W:0]      dif_re;
    logic signed [DATA_W:0]      dif_im;
    logic signed [DATA_W+TW_W:0] prod_re;
    logic signed [DATA_W+TW_W:0] prod_im;
    logic signed [DATA_W+TW_W:0] rot_re;
    logic signed [DATA_W+TW_W:0] rot_im;

    always_comb begin
        sum_re  = a_i.re + b_i.re;           // One growth bit
        sum_im  = a_i.im + b_i.im;
        dif_re  = b_i.re - a_i.re;
        dif_im  = b_i.im - a_i.im;

        // Complex multiply of the stored difference
        prod_re = b_i.re * tw_i.re - b_i.im * tw_i.im;
        prod_im = b_i.re * tw_i.im + b_i.im * tw_i.re;
        rot_re  = prod_re >>> TW_FRAC;       // Back to sample scale
        rot_im  = prod_im >>> TW_FRAC;

        if (compute_i) begin
            out_o.re = sum_re[DATA_W:1];     // Halve
            out_o.im = sum_im[DATA_W:1];
            fb_o.re  = dif_re[DATA_W:1];
            fb_o.im  = dif_im[DATA_W:1];
        end else begin
            out_o.re = rot_re[DATA_W-1:0];
            out_o.im = rot_im[DATA_W-1:0];
            fb_o     = a_i;                  // Park first half sample
        end
    end

endmodule

`default_nettype wire

//--- hw/butterfly/twiddle_rom.sv
/*
 * Twiddle table
 * W16^k for k 0 to 7 in signed Q1.6, re = cos, im = -sin
 */
`default_nettype none

module twiddle_rom (
    input  logic [2:0]   idx_i,
    output fft_pkg::tw_t tw_o
);

    // Values are round(64 * cos) and round(-64 * sin) of 2*pi*k/16
    always_comb begin
        case (idx_i)
            3'd0: tw_o = '{re:  8'sd64, im:   8'sd0};
            3'd1: tw_o = '{re:  8'sd59, im: -8'sd24};
            3'd2: tw_o = '{re:  8'sd45, im: -8'sd45};
            3'd3: tw_o = '{re:  8'sd24, im: -8'sd59};
            3'd4: tw_o = '{re:   8'sd0, im: -8'sd64};   // -j
            3'd5: tw_o = '{re: -8'sd24, im: -8'sd59};
            3'd6: tw_o = '{re: -8'sd45, im: -8'sd45};
            3'd7: tw_o = '{re: -8'sd59, im: -8'sd24};
            default: tw_o = '{re: 8'sd64, im: 8'sd0};
        endcase
    end

endmodule

`default_nettype wire

//--- hw/delay_line.sv
/*
 * Feedback delay line
 * DEPTH-entry shift register of complex samples, advances on en_i
 */
`default_nettype none

module delay_line #(
    parameter int DEPTH = 8
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           en_i,
    input  fft_pkg::cplx_t data_i,
    output fft_pkg::cplx_t data_o
);
    import fft_pkg::*;

    cplx_t [DEPTH-1:0] sr_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sr_q <= '0;
        end else if (en_i) begin
            sr_q[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                sr_q[i] <= sr_q[i-1];
            end
        end
    end

    assign data_o = sr_q[DEPTH-1];          // Oldest entry

endmodule

`default_nettype wire

//--- hw/fft_ctrl.sv
/*
 * FFT pipeline control
 * Registers the input strobe and sample, counts steps and derives the
 * butterfly phase and twiddle index of every stage
 */
`default_nettype none

module fft_ctrl (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         valid_i,
    input  fft_pkg::cplx_t                               data_i,
    output logic                                         step_o,
    output fft_pkg::cplx_t                               sample_o,
    output fft_pkg::stage_ctrl_t [fft_pkg::N_STAGES-1:0] stage_ctrl_o,
    output logic                                         valid_o
);
    import fft_pkg::*;

    logic [4:0]                 cnt_q;      // Accepted samples
    logic                       primed_q;
    logic [N_STAGES-1:0][3:0]   pos;        // Position inside each stage window
    stage_ctrl_t [N_STAGES-1:0] ctrl_d;

    // ******************************************************************
    // Stage phases from the shared step count
    // ******************************************************************
    always_comb begin
        for (int s = 0; s < N_STAGES; s++) begin
            pos[s]            = 4'(cnt_q - STAGE_OFS[s]);
            // Delay of stage s+1 is 8 >> s, so this bit is (pos / D) odd
            ctrl_d[s].compute = pos[s][N_STAGES-1-s];
            ctrl_d[s].tw_idx  = 3'(pos[s] << s);    // (pos mod D) * 8/D
        end
    end

    // ******************************************************************
    // Input and control registers
    // ******************************************************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            step_o       <= 1'b0;
            sample_o     <= '0;
            stage_ctrl_o <= '0;
            cnt_q        <= '0;
            primed_q     <= 1'b0;
            valid_o      <= 1'b0;
        end else begin
            step_o   <= valid_i;
            sample_o <= data_i;
            valid_o  <= step_o & primed_q;  // Qualified by pipeline fill
            if (valid_i) begin
                cnt_q        <= cnt_q + 5'd1;
                stage_ctrl_o <= ctrl_d;     // Travels with sample_o
                if (cnt_q == 5'(PIPE_LAT - 1)) begin
                    primed_q <= 1'b1;       // Sticky once filled
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/r2sdf_stage.sv
/*
 * R2SDF stage
 * Butterfly with feedback delay of 16 >> STAGE samples, twiddle lookup
 * and an output register that advances with the pipeline step
 */
`default_nettype none

module r2sdf_stage #(
    parameter int STAGE = 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 en_i,
    input  fft_pkg::stage_ctrl_t ctrl_i,
    input  fft_pkg::cplx_t       data_i,
    output fft_pkg::cplx_t       data_o
);
    import fft_pkg::*;

    cplx_t fb_in;                           // Butterfly into delay
    cplx_t fb_out;                          // Delay into butterfly
    cplx_t bf_out;
    tw_t   tw;

    // ******************************************************************
    // Feedback loop
    // ******************************************************************
    delay_line #(
        .DEPTH  (FFT_N >> STAGE)
    ) u_delay (
        .clk    (clk),
        .rst    (rst),
        .en_i   (en_i),
        .data_i (fb_in),
        .data_o (fb_out)
    );

    twiddle_rom u_twiddle (
        .idx_i  (ctrl_i.tw_idx),
        .tw_o   (tw)
    );

    r2_butterfly u_butterfly (
        .compute_i (ctrl_i.compute),
        .a_i       (data_i),
        .b_i       (fb_out),
        .tw_i      (tw),
        .out_o     (bf_out),
        .fb_o      (fb_in)
    );

    // ******************************************************************
    // Output register
    // ******************************************************************
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            data_o <= '0;
        end else if (en_i) begin
            data_o <= bf_out;               // Next stage reads it on the next step
        end
    end

endmodule

`default_nettype wire

//--- hw/fft16_top.sv
/*
 * 16-point streaming FFT
 * Control block and four R2SDF stages, output in bit-reversed order
 * scaled by 1/16
 */
`default_nettype none

module fft16_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           valid_i,
    input  fft_pkg::cplx_t data_i,
    output logic           valid_o,
    output fft_pkg::cplx_t data_o
);
    import fft_pkg::*;

    logic                       step;       // Pipeline enable
    cplx_t                      sample;
    stage_ctrl_t [N_STAGES-1:0] stage_ctrl;
    cplx_t                      s1_data;
    cplx_t                      s2_data;
    cplx_t                      s3_data;

    fft_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (valid_i),
        .data_i       (data_i),
        .step_o       (step),
        .sample_o     (sample),
        .stage_ctrl_o (stage_ctrl),
        .valid_o      (valid_o)
    );

    // ******************************************************************
    // Stage chain with delays 8, 4, 2, 1
    // ******************************************************************
    r2sdf_stage #(.STAGE(1)) u_stage1 (
        .clk (clk), .rst (rst), .en_i (step),
        .ctrl_i (stage_ctrl[0]), .data_i (sample), .data_o (s1_data)
    );

    r2sdf_stage #(.STAGE(2)) u_stage2 (
        .clk (clk), .rst (rst), .en_i (step),
        .ctrl_i (stage_ctrl[1]), .data_i (s1_data), .data_o (s2_data)
    );

    r2sdf_stage #(.STAGE(3)) u_stage3 (
        .clk (clk), .rst (rst), .en_i (step),
        .ctrl_i (stage_ctrl[2]), .data_i (s2_data), .data_o (s3_data)
    );

    r2sdf_stage #(.STAGE(4)) u_stage4 (
        .clk (clk), .rst (rst), .en_i (step),
        .ctrl_i (stage_ctrl[3]), .data_i (s3_data), .data_o (data_o)
    );

endmodule

`default_nettype wire

//--- tests/fft16_tb.sv
/*
 * FFT16 testbench
 * Impulse, constant and random frames with gaps, checked against a DFT model
 */
`default_nettype none

module fft16_tb;
    import fft_pkg::*;

    localparam int    N_RAND   = 6;                         // Random frames
    localparam int    N_FRAMES = 2 + N_RAND + 2;            // Plus two flush frames
    localparam int    WD_CYCLES = (N_FRAMES + 3) * FFT_N * 4;
    localparam real   PI       = 3.14159265358979;
    localparam int    FIRST_J  = PIPE_LAT - 1;              // Sample index of first bin

    logic       clk;
    logic       rst;
    logic       valid_i;
    cplx_t      data_i;
    logic       valid_o;
    cplx_t      data_o;

    logic [31:0] rng = 32'hc722;
    cplx_t       in_q[$];                                   // Accepted samples
    int          acc_cnt;
    int          out_cnt;
    logic [1:0]  valid_hist;                                // Expected valid_o pipeline
    int          val_errs;
    int          vld_errs;
    int          other_errs;

    fft16_top DUT (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid_i),
        .data_i  (data_i),
        .valid_o (valid_o),
        .data_o  (data_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic int bitrev4(input int v);
        return {v[0], v[1], v[2], v[3]};
    endfunction

    function automatic real real_abs(input real v);
        return (v < 0.0) ? -v : v;
    endfunction

    function automatic int round_real(input real v);
        return (v >= 0.0) ? $rtoi(v + 0.5) : -$rtoi(-v + 0.5);
    endfunction

    // ******************************************************************
    // Reference model and checks
    // ******************************************************************
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            acc_cnt    <= 0;
            valid_hist <= '0;
        end else begin
            // valid_o two cycles later, once 19 samples are in
            valid_hist <= {valid_hist[0], valid_i && (acc_cnt >= FIRST_J)};
            if (valid_i) begin
                acc_cnt <= acc_cnt + 1;
                in_q.push_back(data_i);
            end
        end
    end

    reset_quiet: assert property (@(posedge clk) !rst |-> !valid_o)
        else begin
            vld_errs++;
            $display("[FAIL] valid_o during reset expected %h got %h",
                     1'b0, $sampled(valid_o));
        end

    valid_timing: assert property (@(posedge clk) disable iff (!rst)
        valid_o == valid_hist[1])
        else begin
            vld_errs++;
            $display("[FAIL] valid_o expected %h got %h",
                     $sampled(valid_hist[1]), $sampled(valid_o));
        end

    // Output k is element k of the bit-reversed bin stream
    task automatic check_bin(input int idx);
        int  frame;
        int  bin;
        real acc_re;
        real acc_im;
        real ang;
        real xr;
        real xi;
        real tol;
        frame  = idx / FFT_N;
        bin    = bitrev4(idx % FFT_N);
        acc_re = 0.0;
        acc_im = 0.0;
        for (int n = 0; n < FFT_N; n++) begin
            xr     = real'(in_q[frame*FFT_N + n].re);
            xi     = real'(in_q[frame*FFT_N + n].im);
            ang    = -2.0 * PI * real'(bin * n) / real'(FFT_N);
            acc_re += xr * $cos(ang) - xi * $sin(ang);
            acc_im += xr * $sin(ang) + xi * $cos(ang);
        end
        acc_re = acc_re / real'(FFT_N);
        acc_im = acc_im / real'(FFT_N);
        tol    = (frame < 2) ? 0.001 : 64.0;                // Directed frames are exact
        bin_re: assert (real_abs(real'(data_o.re) - acc_re) <= tol)
            else begin
                val_errs++;
                $display("[FAIL] data_o.re frame %0d bin %0d expected %h got %h",
                         frame, bin, 16'(round_real(acc_re)), data_o.re);
            end
        bin_im: assert (real_abs(real'(data_o.im) - acc_im) <= tol)
            else begin
                val_errs++;
                $display("[FAIL] data_o.im frame %0d bin %0d expected %h got %h",
                         frame, bin, 16'(round_real(acc_im)), data_o.im);
            end
    endtask

    always @(posedge clk) begin
        if (rst && valid_o) begin
            check_bin(out_cnt);
            out_cnt++;
        end
    end

    // ******************************************************************
    // Stimulus
    // ******************************************************************
    task automatic send_sample(input int re, input int im);
        while (next_rand() % 4 == 0) begin                  // Random gap
            valid_i = 1'b0;
            @(posedge clk);
            #1;
        end
        valid_i   = 1'b1;
        data_i.re = 16'(re);
        data_i.im = 16'(im);
        @(posedge clk);
        #1;
    endtask

    initial begin
        rst        = 1'b0;
        valid_i    = 1'b0;
        data_i     = '0;
        out_cnt    = 0;
        val_errs   = 0;
        vld_errs   = 0;
        other_errs = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;

        send_sample(1600, 0);                               // Impulse frame
        for (int i = 1; i < FFT_N; i++) send_sample(0, 0);
        for (int i = 0; i < FFT_N; i++) send_sample(320, 160);
        for (int i = 0; i < N_RAND * FFT_N; i++) begin
            send_sample(int'(next_rand() % 32'd16001) - 8000,
                        int'(next_rand() % 32'd16001) - 8000);
        end
        for (int i = 0; i < 2 * FFT_N; i++) send_sample(0, 0);  // Push the last frame out
        valid_i = 1'b0;
        data_i  = '0;
        repeat (8) @(posedge clk);

        out_count: assert (out_cnt == acc_cnt - FIRST_J)
            else begin
                other_errs++;
                $display("Number of output bins does not match the accepted samples");
            end

        $display("Errors: value %0d, valid %0d, other %0d", val_errs, vld_errs, other_errs);
        if (val_errs + vld_errs + other_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Watchdog expired before the stimulus finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
common/fft_pkg.sv
hw/butterfly/r2_butterfly.sv
hw/butterfly/twiddle_rom.sv
hw/delay_line.sv
hw/fft_ctrl.sv
hw/r2sdf_stage.sv
hw/fft16_top.sv
tests/fft16_tb.sv

//--- Makefile
# Verilator build and run of the 16-point FFT testbench

VERILATOR ?= verilator
TOP       ?= fft16_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
